//--- bus_phase_gen.sv
// 4-phase counter, four slot sequencer and slot type classification
`timescale 1ns/100ps

module bus_phase_gen
	import st_bus_pkg::*;
(
	input  logic       clk_32,
	input  logic       berr_reset,
	input  logic       fast_slot,
	output logic [1:0] phase,
	output slot_t      slot
);

	// position 0..3 inside the video/cpu/video/extra sequence
	logic [1:0] slot_idx;
	logic [1:0] idx_nxt;
	slot_t      slot_nxt;

	assign idx_nxt = slot_idx + 2'd1;

	// type of the slot that starts at the next phase wrap
	always_comb begin
		case (idx_nxt)
			2'd1: slot_nxt = slot_cpu;
			// extra slot goes to the cpu only in fast mode
			2'd3: slot_nxt = fast_slot ? slot_cpu_fast : slot_internal;
			default: slot_nxt = slot_video;
		endcase
	end

	// slot type is registered so it stays fixed for all four phases
	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			phase    <= 2'd0;
			slot_idx <= 2'd0;
			slot     <= slot_video;
		end else begin
			phase <= phase + 2'd1;
			if (phase == 2'd3) begin
				slot_idx <= idx_nxt;
				slot     <= slot_nxt;
			end
		end
	end

	// a slot only starts when the phase counter wraps
	a_slot_on_wrap : assert property (@(posedge clk_32) disable iff (berr_reset)
		!$stable(slot) |-> (phase == 2'd0));

endmodule

//--- bus_req_if.sv
// latched cpu request bus with latch, decode and irq modports
`timescale 1ns/100ps
`include "st_bus_defines.svh"

interface bus_req_if;

	// word address, byte address is addr*2
	logic [`ST_ADDR_W-1:0] addr;
	// high for a read
	logic                  rw;
	// active low byte strobes
	logic                  uds_n;
	logic                  lds_n;
	logic [`ST_FC_W-1:0]   fc;
	// address strobe for the current slot
	logic                  as;
	// the current slot belongs to the cpu
	logic                  cpu_slot;

	// all members are levels that hold for a whole slot
	modport latch (output addr, rw, uds_n, lds_n, fc, as, cpu_slot);

	modport decode (input addr, rw, uds_n, lds_n, fc, as, cpu_slot);

	// interrupt logic only looks at acknowledge cycles
	modport irq (input as, fc, addr, cpu_slot);

endinterface

//--- cpu_req_latch.sv
// cpu request latch, address strobe and cpu slot flag for the bus stage
`timescale 1ns/100ps
`include "st_bus_defines.svh"

module cpu_req_latch
	import st_bus_pkg::*;
(
	input  logic                  clk_32,
	input  logic                  berr_reset,
	input  logic [1:0]            phase,
	input  slot_t                 slot,
	input  logic                  cpu_req,
	input  logic [`ST_ADDR_W-1:0] cpu_addr,
	input  logic                  cpu_rw,
	input  logic                  cpu_uds_n,
	input  logic                  cpu_lds_n,
	input  logic [`ST_FC_W-1:0]   cpu_fc,
	bus_req_if.latch              bus
);

	// sample the cpu at the last phase so the new request covers the
	// whole following slot, a cpu moving on mid-slot is not seen
	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			bus.as    <= 1'b0;
			bus.addr  <= '0;
			bus.rw    <= 1'b1;
			bus.uds_n <= 1'b1;
			bus.lds_n <= 1'b1;
			bus.fc    <= '0;
		end else if (phase == 2'd3) begin
			// as is simply the request level seen at the slot edge
			bus.as    <= cpu_req;
			bus.addr  <= cpu_addr;
			bus.rw    <= cpu_rw;
			bus.uds_n <= cpu_uds_n;
			bus.lds_n <= cpu_lds_n;
			bus.fc    <= cpu_fc;
		end
	end

	// slot is itself loaded on the phase 3 edge with the next slot type,
	// so this flag switches together with the latched request
	assign bus.cpu_slot = (slot == slot_cpu) || (slot == slot_cpu_fast);

	// the whole request moves as one, only at the start of a slot
	a_bus_stable : assert property (@(posedge clk_32) disable iff (berr_reset)
		!$stable({bus.as, bus.addr, bus.rw, bus.uds_n, bus.lds_n, bus.fc, bus.cpu_slot})
		|-> (phase == 2'd0));

endmodule

//--- irq_ctrl.sv
// vbi/hbi edge latches, ipl priority encoder and autovector supply
`timescale 1ns/100ps
`include "st_bus_defines.svh"

module irq_ctrl
	import st_bus_pkg::*;
(
	input  logic                 clk_32,
	input  logic                 berr_reset,
	input  logic                 st_vs,
	input  logic                 st_hs,
	input  logic                 mfp_irq,
	bus_req_if.irq               bus,
	output logic [2:0]           ipl,
	output logic [`ST_VEC_W-1:0] vector
);

	// bits 0 and 1 synchronize, bit 2 keeps the previous level
	logic [2:0] vs_sync;
	logic [2:0] hs_sync;
	logic       vbi;
	logic       hbi;
	logic       iack_cyc;
	logic       vbi_ack;
	logic       hbi_ack;

	// acknowledge on the bus during a cpu slot
	assign iack_cyc = bus.as && bus.cpu_slot && (bus.fc == `ST_FC_IACK);
	assign vbi_ack  = iack_cyc && (bus.addr[2:0] == lvl_vbi);
	assign hbi_ack  = iack_cyc && (bus.addr[2:0] == lvl_hbi);

	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			vs_sync <= '0;
			hs_sync <= '0;
			vbi     <= 1'b0;
			hbi     <= 1'b0;
		end else begin
			vs_sync <= {vs_sync[1:0], st_vs};
			hs_sync <= {hs_sync[1:0], st_hs};
			// acknowledge wins over a new edge in the same cycle
			if (vbi_ack) begin
				vbi <= 1'b0;
			end else if (vs_sync[1] && !vs_sync[2]) begin
				vbi <= 1'b1;
			end
			if (hbi_ack) begin
				hbi <= 1'b0;
			end else if (hs_sync[1] && !hs_sync[2]) begin
				hbi <= 1'b1;
			end
		end
	end

	// ipl is active low with bit 0 tied high, mfp 6, vbi 4, hbi 2
	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			ipl <= 3'd7;
		end else if (mfp_irq) begin
			ipl <= 3'd1;
		end else if (vbi) begin
			ipl <= 3'd3;
		end else if (hbi) begin
			ipl <= 3'd5;
		end else begin
			ipl <= 3'd7;
		end
	end

	// vbi and hbi are autovectored by the st, the mfp drives its own
	assign vector = vbi_ack ? `ST_VEC_VBI : (hbi_ack ? `ST_VEC_HBI : '0);

	a_ipl_nonzero : assert property (@(posedge clk_32) disable iff (berr_reset)
		ipl != 3'd0);

endmodule

//--- run.sh
#!/bin/sh
# verilator build and run, result taken from the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_st_bus -f st_bus_top.f \
	-o sim_st_bus && ./obj_dir/sim_st_bus > sim.log 2>&1
cat sim.log
grep -q "^Regression passed$" sim.log && echo "run ok" || { echo "run not ok"; exit 1; }

//--- st_addr_decoder.sv
// st memory and i/o map, dtack generation and bus error timeout
`timescale 1ns/100ps
`include "st_bus_defines.svh"

module st_addr_decoder
	import st_bus_pkg::*;
(
	input  logic      clk_32,
	input  logic      berr_reset,
	input  logic [1:0] phase,
	input  mem_cfg_t  mem_cfg,
	input  logic      ste,
	bus_req_if.decode bus,
	output dev_t      dev_sel,
	output logic      dtack,
	output logic      berr
);

	logic [`ST_ADDR_W:0]   baddr;
	logic [7:0]            page;
	logic [15:0]           io_off;
	logic                  low_rom;
	logic                  big_mem;
	logic                  ram_hit;
	logic                  rom_hit;
	logic                  io_hit;
	logic                  word_acc;
	logic                  iack;
	logic                  iack_auto;
	logic [`ST_BERR_W-1:0] berr_cnt;
	dev_t                  io_dev;

	// inclusive byte offset window inside the i/o page
	function automatic logic in_win(input logic [15:0] off, input logic [15:0] lo,
		input logic [15:0] hi);
		in_win = (off >= lo) && (off <= hi);
	endfunction

	// byte address, bit 0 comes from the strobes
	assign baddr    = {bus.addr, 1'b0};
	assign page     = baddr[`ST_ADDR_W -: 8];
	assign io_off   = baddr[15:0];
	assign word_acc = !bus.uds_n && !bus.lds_n;

	// reset vector fetch reads rom through the first 8 bytes
	assign low_rom = (baddr[`ST_ADDR_W:3] == '0);
	assign big_mem = (mem_cfg == mem_8m) || (mem_cfg == mem_14m);

	// first 4 MB always, 8 MB and 14 MB extend upward
	assign ram_hit = !low_rom && ((page[7:6] == 2'b00) ||
		(big_mem && (page[7:6] == 2'b01)) ||
		((mem_cfg == mem_14m) && ((page[7:6] == 2'b10) || (page[7:5] == 3'b110))));

	// 256k tos at e00000, cartridge and 192k tos from fa0000 to feffff
	assign rom_hit = low_rom || (page[7:2] == 6'b111000) ||
		((page >= 8'hfa) && (page <= 8'hfe));

	assign io_hit = (page == `ST_IO_PAGE);

	// cpu space cycle, addr[2:0] carries the level
	assign iack      = (bus.fc == `ST_FC_IACK);
	assign iack_auto = iack && ((bus.addr[2:0] == lvl_vbi) || (bus.addr[2:0] == lvl_hbi));

	// per chip selects in the i/o page
	always_comb begin
		io_dev = dev_none;
		if (in_win(io_off, 16'h8000, 16'h800d)) begin
			io_dev = dev_mmu;
		end else if (in_win(io_off, 16'h8200, 16'h820d) ||
			(ste && in_win(io_off, 16'h820e, 16'h820f)) ||
			in_win(io_off, 16'h8240, 16'h827f)) begin
			// STE adds the line offset pair at 820e
			io_dev = dev_shifter;
		end else if ((word_acc && in_win(io_off, 16'h8604, 16'h8607)) ||
			in_win(io_off, 16'h8608, 16'h860d) ||
			(ste && in_win(io_off, 16'h860e, 16'h860f))) begin
			// fdc/acsi data and control only answer word accesses
			io_dev = dev_dma;
		end else if (in_win(io_off, 16'h8800, 16'h88ff)) begin
			io_dev = dev_psg;
		end else if (ste && in_win(io_off, 16'h8900, 16'h893f)) begin
			io_dev = dev_ste_snd;
		end else if (ste && in_win(io_off, 16'h8a00, 16'h8a3f)) begin
			io_dev = dev_blitter;
		end else if (ste && in_win(io_off, 16'h9200, 16'h923f)) begin
			io_dev = dev_ste_joy;
		end else if (!bus.lds_n && in_win(io_off, 16'hfa00, 16'hfa3f)) begin
			// mfp sits on the odd byte lane
			io_dev = dev_mfp;
		end else if (in_win(io_off, 16'hfc00, 16'hfdff)) begin
			io_dev = dev_acia;
		end
	end

	always_comb begin
		if (iack) begin
			// only the mfp supplies its own vector
			dev_sel = (bus.addr[2:0] == lvl_mfp) ? dev_mfp : dev_none;
		end else if (rom_hit) begin
			// rom write gets no answer and ends in a bus error
			dev_sel = bus.rw ? dev_rom : dev_none;
		end else if (ram_hit) begin
			dev_sel = dev_ram;
		end else if (io_hit) begin
			dev_sel = io_dev;
		end else begin
			dev_sel = dev_none;
		end
	end

	// autovector levels are answered even though no device is selected
	assign dtack = bus.as && bus.cpu_slot && ((dev_sel != dev_none) || iack_auto);

	// count cpu slots that end with as but no dtack, freeze at the limit
	always_ff @(posedge clk_32 or posedge berr_reset) begin
		if (berr_reset) begin
			berr_cnt <= '0;
		end else if (bus.cpu_slot && (phase == 2'd3) && (berr_cnt != `ST_BERR_LIMIT)) begin
			if (!bus.as || dtack) begin
				berr_cnt <= '0;
			end else begin
				berr_cnt <= berr_cnt + 1'b1;
			end
		end
	end

	assign berr = (berr_cnt == `ST_BERR_LIMIT);

	// a cpu waiting on a bus error must not get a normal cycle end too
	a_berr_no_dtack : assert property (@(posedge clk_32) disable iff (berr_reset)
		!(berr && dtack));

endmodule

//--- st_bus_defines.svh
// widths, bus error limit, autovectors, fc code and i/o page constants
`ifndef ST_BUS_DEFINES_SVH
`define ST_BUS_DEFINES_SVH

// cpu word address, byte bit 0 is carried by uds_n/lds_n
`define ST_ADDR_W 23

// 68000 function code width
`define ST_FC_W 3

// timeout counter width and the count that raises berr
`define ST_BERR_W 4
`define ST_BERR_LIMIT 4'd15

// vector bus width
`define ST_VEC_W 8

// vbi answers on level 4, hbi on level 2
`define ST_VEC_VBI 8'h1c
`define ST_VEC_HBI 8'h1a

// upper byte of the byte address for the i/o page
`define ST_IO_PAGE 8'hff

// cpu space cycle, used for interrupt acknowledge
`define ST_FC_IACK 3'b111

`endif

//--- st_bus_pkg.sv
// slot, responder device, memory size and interrupt level enums
package st_bus_pkg;

	// one 8 MHz slot of the four slot bus sequence
	typedef enum logic [1:0] {
		slot_video    = 2'd0,
		slot_cpu      = 2'd1,
		slot_cpu_fast = 2'd2,
		slot_internal = 2'd3
	} slot_t;

	// responder picked by the address decoder
	typedef enum logic [3:0] {
		dev_none    = 4'd0,
		dev_ram     = 4'd1,
		dev_rom     = 4'd2,
		dev_mmu     = 4'd3,
		dev_shifter = 4'd4,
		dev_dma     = 4'd5,
		dev_psg     = 4'd6,
		dev_ste_snd = 4'd7,
		dev_blitter = 4'd8,
		dev_ste_joy = 4'd9,
		dev_mfp     = 4'd10,
		dev_acia    = 4'd11
	} dev_t;

	// st ram size setting
	typedef enum logic [2:0] {
		mem_512k = 3'd0,
		mem_1m   = 3'd1,
		mem_2m   = 3'd2,
		mem_4m   = 3'd3,
		mem_8m   = 3'd4,
		mem_14m  = 3'd5
	} mem_cfg_t;

	// interrupt levels seen on addr[2:0] of an acknowledge cycle
	typedef enum logic [2:0] {
		lvl_hbi = 3'd2,
		lvl_vbi = 3'd4,
		lvl_mfp = 3'd6
	} irq_lvl_t;

endpackage

//--- st_bus_top.f
+incdir+.
st_bus_pkg.sv
bus_req_if.sv
bus_phase_gen.sv
cpu_req_latch.sv
st_addr_decoder.sv
irq_ctrl.sv
st_bus_top.sv
tb_clock.sv
tb_st_bus.sv

//--- st_bus_top.sv
// st cpu bus front end top level with plain ports
`timescale 1ns/100ps
`include "st_bus_defines.svh"

module st_bus_top
	import st_bus_pkg::*;
(
	input  logic                  clk_32,
	input  logic                  berr_reset,
	input  logic                  fast_slot,
	input  logic [2:0]            mem_cfg,
	input  logic                  ste,
	input  logic                  cpu_req,
	input  logic [`ST_ADDR_W-1:0] cpu_addr,
	input  logic                  cpu_rw,
	input  logic                  cpu_uds_n,
	input  logic                  cpu_lds_n,
	input  logic [`ST_FC_W-1:0]   cpu_fc,
	input  logic                  st_vs,
	input  logic                  st_hs,
	input  logic                  mfp_irq,
	output logic [1:0]            slot,
	output logic [3:0]            dev_sel,
	output logic                  dtack,
	output logic                  berr,
	output logic [2:0]            ipl,
	output logic [`ST_VEC_W-1:0]  vector
);

	logic [1:0] phase;
	slot_t      slot_type;
	dev_t       dev_type;

	// one slot wide copy of the cpu request
	bus_req_if i_bus ();

	bus_phase_gen i_bus_phase_gen (.clk_32(clk_32), .berr_reset(berr_reset),
		.fast_slot(fast_slot), .phase(phase), .slot(slot_type));

	cpu_req_latch i_cpu_req_latch (.clk_32(clk_32), .berr_reset(berr_reset),
		.phase(phase), .slot(slot_type), .cpu_req(cpu_req), .cpu_addr(cpu_addr),
		.cpu_rw(cpu_rw), .cpu_uds_n(cpu_uds_n), .cpu_lds_n(cpu_lds_n),
		.cpu_fc(cpu_fc), .bus(i_bus.latch));

	st_addr_decoder i_st_addr_decoder (.clk_32(clk_32), .berr_reset(berr_reset),
		.phase(phase), .mem_cfg(mem_cfg_t'(mem_cfg)), .ste(ste), .bus(i_bus.decode),
		.dev_sel(dev_type), .dtack(dtack), .berr(berr));

	// interrupt acknowledge is taken straight from the latched request
	irq_ctrl i_irq_ctrl (.clk_32(clk_32), .berr_reset(berr_reset), .st_vs(st_vs),
		.st_hs(st_hs), .mfp_irq(mfp_irq), .bus(i_bus.irq), .ipl(ipl), .vector(vector));

	// enums leave the top as plain vectors
	assign slot    = slot_type;
	assign dev_sel = dev_type;

endmodule

//--- tb_clock.sv
// testbench clock source and power-on reset with an extra reset request input
`timescale 1ns/100ps

module tb_clock #(
	parameter int half_period  = 10,
	parameter int reset_cycles = 16
) (
	input  logic rst_req,
	output logic clk_32,
	output logic berr_reset
);

	logic rst_init;

	// 20 ns period
	initial begin
		clk_32 = 1'b0;
		forever begin
			#(half_period);
			clk_32 = ~clk_32;
		end
	end

	// power-on reset, released on a rising edge
	initial begin
		rst_init = 1'b1;
		repeat (reset_cycles) @(posedge clk_32);
		rst_init <= 1'b0;
	end

	// later resets come from the test sequence
	assign berr_reset = rst_init || rst_req;

endmodule

//--- tb_st_bus.sv
// testbench top with random and directed stimulus, cycle model of the bus front end and checks
`timescale 1ns/100ps
`include "st_bus_defines.svh"

module tb_st_bus
	import st_bus_pkg::*;
();

	localparam int n_rand      = 3000;
	localparam int test_cycles = 16 + n_rand + 1200;
	localparam int out_berr    = 0;
	localparam int out_ipl     = 1;
	localparam int out_vector  = 2;

	logic                  clk_32;
	logic                  berr_reset;
	logic                  rst_req;
	logic                  fast_slot;
	logic [2:0]            mem_cfg;
	logic                  ste;
	logic                  cpu_req;
	logic [`ST_ADDR_W-1:0] cpu_addr;
	logic                  cpu_rw;
	logic                  cpu_uds_n;
	logic                  cpu_lds_n;
	logic [`ST_FC_W-1:0]   cpu_fc;
	logic                  st_vs;
	logic                  st_hs;
	logic                  mfp_irq;
	logic [1:0]            slot;
	logic [3:0]            dev_sel;
	logic                  dtack;
	logic                  berr;
	logic [2:0]            ipl;
	logic [7:0]            vector;
	integer                seed;

	// model state: phase, slot, latched request, timeout and interrupt flags
	logic [1:0]            m_phase;
	logic [1:0]            m_idx;
	logic [1:0]            m_slot;
	logic                  m_valid;
	logic                  m_as;
	logic [`ST_ADDR_W-1:0] m_addr;
	logic                  m_rw;
	logic                  m_uds;
	logic                  m_lds;
	logic [2:0]            m_fc;
	logic [3:0]            m_cnt;
	logic [2:0]            m_vs;
	logic [2:0]            m_hs;
	logic                  m_vbi;
	logic                  m_hbi;
	logic [2:0]            m_ipl;

	tb_clock i_tb_clock (.*);

	st_bus_top i_st_bus_top (.*);

	function automatic logic [31:0] rand_word();
		rand_word = $random(seed);
	endfunction

	function automatic logic in_range(input logic [15:0] v, input logic [15:0] lo,
		input logic [15:0] hi);
		return (v >= lo) && (v <= hi);
	endfunction

	// i/o page chip selects by byte offset
	function automatic dev_t io_map(input logic [15:0] o, input logic word, input logic lds_n,
		input logic st);
		if (in_range(o, 16'h8000, 16'h800d))
			return dev_mmu;
		if (in_range(o, 16'h8200, 16'h820d) || (st && in_range(o, 16'h820e, 16'h820f)) ||
			in_range(o, 16'h8240, 16'h827f))
			return dev_shifter;
		// dma registers at 8604 need both strobes
		if ((word && in_range(o, 16'h8604, 16'h8607)) || in_range(o, 16'h8608, 16'h860d) ||
			(st && in_range(o, 16'h860e, 16'h860f)))
			return dev_dma;
		if (in_range(o, 16'h8800, 16'h88ff))
			return dev_psg;
		if (st && in_range(o, 16'h8900, 16'h893f))
			return dev_ste_snd;
		if (st && in_range(o, 16'h8a00, 16'h8a3f))
			return dev_blitter;
		if (st && in_range(o, 16'h9200, 16'h923f))
			return dev_ste_joy;
		if (!lds_n && in_range(o, 16'hfa00, 16'hfa3f))
			return dev_mfp;
		if (in_range(o, 16'hfc00, 16'hfdff))
			return dev_acia;
		return dev_none;
	endfunction

	// expected responder for a request, decoded on the byte address
	function automatic dev_t model_dev(input logic [`ST_ADDR_W-1:0] a, input logic rw,
		input logic uds_n, input logic lds_n, input logic [2:0] fc, input logic [2:0] cfg,
		input logic st);
		logic [23:0] b;
		logic [7:0]  pg;
		b  = {a, 1'b0};
		pg = b[23:16];
		// only level 6 has a device behind the acknowledge
		if (fc == `ST_FC_IACK)
			return (a[2:0] == 3'd6) ? dev_mfp : dev_none;
		if ((b < 24'h8) || ((pg >= 8'he0) && (pg <= 8'he3)) ||
			((pg >= 8'hfa) && (pg <= 8'hfe)))
			return rw ? dev_rom : dev_none;
		if ((pg < 8'h40) || ((pg < 8'h80) && ((cfg == mem_8m) || (cfg == mem_14m))) ||
			((pg < 8'he0) && (cfg == mem_14m)))
			return dev_ram;
		if (pg == `ST_IO_PAGE)
			return io_map(b[15:0], !uds_n && !lds_n, lds_n, st);
		return dev_none;
	endfunction

	// levels 4 and 2 answer without a device
	function automatic logic model_dtack(input dev_t dev, input logic cs);
		logic autovec;
		autovec = (m_fc == `ST_FC_IACK) && ((m_addr[2:0] == 3'd4) || (m_addr[2:0] == 3'd2));
		return m_as && cs && ((dev != dev_none) || autovec);
	endfunction

	function automatic logic [7:0] model_vector(input logic cs);
		if (m_as && cs && (m_fc == `ST_FC_IACK) && (m_addr[2:0] == 3'd4))
			return `ST_VEC_VBI;
		if (m_as && cs && (m_fc == `ST_FC_IACK) && (m_addr[2:0] == 3'd2))
			return `ST_VEC_HBI;
		return 8'h00;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s is %h, expected %h", name, got, exp);
			$display("Regression failed");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			$display("%s", what);
			$display("Regression failed");
			$fatal(1, "directed check");
		end
	endtask

	// window starts, some just below or above a boundary
	function automatic logic [15:0] io_base(input logic [3:0] sel);
		case (sel)
			4'd0: return 16'h8000;
			4'd1: return 16'h8200;
			4'd2: return 16'h8240;
			4'd3: return 16'h8600;
			4'd4: return 16'h8608;
			4'd5: return 16'h8800;
			4'd6: return 16'h8900;
			4'd7: return 16'h8a00;
			4'd8: return 16'h9200;
			4'd9: return 16'hfa00;
			4'd10: return 16'hfc00;
			4'd11: return 16'hfde8;
			4'd12: return 16'h8100;
			4'd13: return 16'h8a30;
			4'd14: return 16'h9230;
			default: return 16'hfa30;
		endcase
	endfunction

	// word address biased to rom, ram and i/o windows
	function automatic logic [`ST_ADDR_W-1:0] pick_addr();
		logic [31:0] r;
		logic [23:0] b;
		r = rand_word();
		case (r[2:0])
			3'd0: b = {21'd0, r[10:8]};
			3'd1: b = {6'b111000, r[9:8], r[31:16]};
			3'd2: b = {8'hfa + 8'(r[10:8] % 3'd5), r[31:16]};
			3'd3: b = {8'(r[15:8] % 8'd224), r[31:16]};
			3'd7: b = r[31:8];
			default: b = {`ST_IO_PAGE, io_base(r[11:8]) + {11'd0, r[20:16]}};
		endcase
		return b[23:1];
	endfunction

	// one cycle of random cpu traffic, config and interrupt inputs
	task automatic drive_random();
		logic [31:0] r;
		r = rand_word();
		cpu_req   <= (r[1:0] != 2'b00);
		cpu_rw    <= r[2];
		cpu_uds_n <= r[3] & r[4];
		cpu_lds_n <= r[5] & r[6];
		if (r[10:8] == 3'd0) begin
			// acknowledge at level 0, 2, 4 or 6
			cpu_fc   <= `ST_FC_IACK;
			cpu_addr <= {20'hfffff, r[12:11], 1'b0};
		end else begin
			cpu_fc   <= (r[15:13] == 3'd7) ? 3'd5 : r[15:13];
			cpu_addr <= pick_addr();
		end
		if (r[21:16] == 6'd0)
			mem_cfg <= r[24:22] % 3'd6;
		if (r[21:16] == 6'd1)
			ste <= r[25];
		if (r[21:16] == 6'd2)
			fast_slot <= r[26];
		if (r[21:16] == 6'd3)
			mfp_irq <= ~mfp_irq;
		if (r[30:27] == 4'd0)
			st_vs <= ~st_vs;
		if (r[30:27] == 4'd1)
			st_hs <= ~st_hs;
	endtask

	task automatic pulse_reset();
		rst_req <= 1'b1;
		repeat (2) @(posedge clk_32);
		rst_req <= 1'b0;
		@(posedge clk_32);
	endtask

	// sample at falling edges, return on a rising edge ready to drive
	task automatic wait_until(input int sel, input logic [7:0] value, input int limit,
		input string what);
		int         n;
		logic [7:0] cur;
		n = 0;
		do begin
			@(negedge clk_32);
			cur = (sel == out_berr) ? {7'd0, berr} :
				(sel == out_ipl) ? {5'd0, ipl} : vector;
			n++;
		end while ((cur !== value) && (n < limit));
		check_true(cur === value, what);
		@(posedge clk_32);
	endtask

	// cycle model, inputs read here are the values before the edge
	always @(posedge clk_32 or posedge berr_reset) begin : reference_model
		logic       cs;
		logic       dt;
		logic       ack;
		logic [1:0] idx_n;
		if (berr_reset) begin
			m_phase = 2'd0;
			m_idx   = 2'd0;
			m_slot  = 2'd0;
			m_valid = 1'b0;
			m_as    = 1'b0;
			m_fc    = 3'd0;
			m_cnt   = 4'd0;
			m_vs    = 3'd0;
			m_hs    = 3'd0;
			m_vbi   = 1'b0;
			m_hbi   = 1'b0;
			m_ipl   = 3'd7;
		end else begin
			cs  = (m_slot == 2'd1) || (m_slot == 2'd2);
			dt  = model_dtack(model_dev(m_addr, m_rw, m_uds, m_lds, m_fc, mem_cfg, ste), cs);
			ack = m_as && cs && (m_fc == `ST_FC_IACK);
			// priority from the flags of the previous cycle
			m_ipl = mfp_irq ? 3'd1 : (m_vbi ? 3'd3 : (m_hbi ? 3'd5 : 3'd7));
			if (ack && (m_addr[2:0] == 3'd4))
				m_vbi = 1'b0;
			else if (m_vs[1] && !m_vs[2])
				m_vbi = 1'b1;
			if (ack && (m_addr[2:0] == 3'd2))
				m_hbi = 1'b0;
			else if (m_hs[1] && !m_hs[2])
				m_hbi = 1'b1;
			m_vs = {m_vs[1:0], st_vs};
			m_hs = {m_hs[1:0], st_hs};
			// timeout steps once per cpu slot and sticks at the limit
			if (cs && (m_phase == 2'd3) && (m_cnt != `ST_BERR_LIMIT))
				m_cnt = (!m_as || dt) ? 4'd0 : m_cnt + 4'd1;
			if (m_phase == 2'd3) begin
				m_valid = 1'b1;
				m_as    = cpu_req;
				m_addr  = cpu_addr;
				m_rw    = cpu_rw;
				m_uds   = cpu_uds_n;
				m_lds   = cpu_lds_n;
				m_fc    = cpu_fc;
				idx_n   = m_idx + 2'd1;
				m_idx   = idx_n;
				if (idx_n == 2'd1)
					m_slot = 2'd1;
				else if (idx_n == 2'd3)
					m_slot = fast_slot ? 2'd2 : 2'd3;
				else
					m_slot = 2'd0;
			end
			m_phase = m_phase + 2'd1;
		end
	end

	// outputs compared at the falling edge, combinational parts use current inputs
	always @(negedge clk_32) begin : compare_outputs
		logic cs;
		dev_t e_dev;
		if (!berr_reset) begin
			cs    = (m_slot == 2'd1) || (m_slot == 2'd2);
			e_dev = model_dev(m_addr, m_rw, m_uds, m_lds, m_fc, mem_cfg, ste);
			check_val("slot", 32'(slot), 32'(m_slot));
			if (m_valid)
				check_val("dev_sel", 32'(dev_sel), 32'(e_dev));
			check_val("dtack", 32'(dtack), 32'(model_dtack(e_dev, cs)));
			check_val("berr", 32'(berr), 32'(m_cnt == `ST_BERR_LIMIT));
			check_val("ipl", 32'(ipl), 32'(m_ipl));
			check_val("vector", 32'(vector), 32'(model_vector(cs)));
		end
	end

	initial begin : watchdog
		repeat (test_cycles + 1000) @(posedge clk_32);
		$display("timeout, the test sequence did not complete");
		$display("Regression failed");
		$fatal(1, "watchdog");
	end

	initial begin : test_sequence
		seed      = 32'h86a2_1df2;
		rst_req   = 1'b0;
		fast_slot = 1'b0;
		mem_cfg   = 3'd0;
		ste       = 1'b0;
		cpu_req   = 1'b0;
		cpu_addr  = '0;
		cpu_rw    = 1'b1;
		cpu_uds_n = 1'b1;
		cpu_lds_n = 1'b1;
		cpu_fc    = 3'd5;
		st_vs     = 1'b0;
		st_hs     = 1'b0;
		mfp_irq   = 1'b0;
		@(posedge clk_32);
		while (berr_reset)
			@(posedge clk_32);

		// random traffic covers slots, memory and i/o decode and interrupts
		repeat (n_rand) begin
			drive_random();
			@(posedge clk_32);
		end

		// unanswered read at e80000 runs into the timeout
		fast_slot <= 1'b0;
		cpu_req   <= 1'b1;
		cpu_addr  <= 23'h740000;
		cpu_fc    <= 3'd5;
		cpu_rw    <= 1'b1;
		cpu_uds_n <= 1'b0;
		cpu_lds_n <= 1'b0;
		st_vs     <= 1'b0;
		st_hs     <= 1'b0;
		mfp_irq   <= 1'b0;
		pulse_reset();
		wait_until(out_berr, 8'd1, 320, "berr did not rise for an unanswered request");
		repeat (64) @(posedge clk_32);
		check_true(berr, "berr dropped before reset");

		// ram read at 020000 keeps the timeout clear
		cpu_addr <= 23'h010000;
		pulse_reset();
		repeat (400) @(posedge clk_32);
		check_true(!berr, "berr rose during a mapped request");

		// video interrupts, acknowledges and autovectors
		cpu_req <= 1'b0;
		pulse_reset();
		st_vs <= 1'b1;
		st_hs <= 1'b1;
		wait_until(out_ipl, 8'd3, 32, "vbi did not raise ipl");
		cpu_req  <= 1'b1;
		cpu_fc   <= `ST_FC_IACK;
		cpu_addr <= {20'hfffff, 3'd4};
		wait_until(out_vector, `ST_VEC_VBI, 64, "no vbi autovector on a level 4 acknowledge");
		cpu_req <= 1'b0;
		wait_until(out_ipl, 8'd5, 32, "hbi not left pending after the vbi acknowledge");
		cpu_req  <= 1'b1;
		cpu_addr <= {20'hfffff, 3'd2};
		wait_until(out_vector, `ST_VEC_HBI, 64, "no hbi autovector on a level 2 acknowledge");
		cpu_req <= 1'b0;
		wait_until(out_ipl, 8'd7, 32, "ipl not idle after both acknowledges");

		$display("Regression passed");
		$finish;
	end

endmodule
